//--- testbench/tx_cases.txt
# W <addr> <rrggbb>                 write one pixel, all fields hex
# F                                 pulse frame_start
# P <txid> <segment> <start pixel>  one packet, txid 01 is a first send
P 01 0000 00
P 01 0001 04
P 02 0000 00  # repeat right after
W 00 112233
W 01 445566
P 03 0000 00  # replay keeps the old pixels
P 01 0002 08
P 01 0003 0c
P 02 0001 04
P 01 0004 10  # reuses slot of segment 0
P 02 0004 10
W 14 a0b0c0
W 17 0f1e2d
P 01 0005 14  # picks up pixels 14 and 17
P 01 0006 18
P 01 0007 1c
P 01 0008 20
P 01 0009 24
P 01 000a 28
P 01 000b 2c
P 01 000c 30
P 01 000d 34
P 01 000e 38
P 01 000f 3c
P 01 0010 00  # pointer wrapped at 64
P 02 000f 3c
P ff 000d 34
F
P 01 0000 00  # new frame, pixel 0 rewritten earlier
P 02 0000 00
W 00 ffffff
P 04 0000 00
P 01 0001 04
F
W 02 7e7f80
P 01 0002 00
P 02 0002 00
P 05 0001 04

//--- sim.f
+incdir+design
design/txmem_pkg.sv
design/pixel_ram.sv
design/segment_store.sv
design/payload_sequencer.sv
design/tx_memory_control.sv
testbench/tb_tx_memory_control.sv

//--- Makefile
BIN = obj_dir/Vtb_tx_memory_control
SRCS = design/txmem_defines.svh design/txmem_pkg.sv design/pixel_ram.sv \
	design/segment_store.sv design/payload_sequencer.sv design/tx_memory_control.sv \
	testbench/tb_tx_memory_control.sv sim.f

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module tb_tx_memory_control \
		--Mdir obj_dir

run: $(BIN) testbench/tx_cases.txt
	$(BIN) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_tx_memory_control.sv
// ----------------------------------------------------------
// testbench for tx payload memory control
// replays the case file of pixel writes, frame starts and
// packets and models payload bytes and start pixels per packet
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "txmem_defines.svh"

module tb_tx_memory_control import txmem_pkg::*; ();

	localparam int HALF        = 4;    // 8 ns clock
	localparam int MAX_RECORDS = 200;  // bound on the case file loop
	localparam int LATCH_CNT   = `TXM_PAYLOAD_START - `TXM_FETCH_AHEAD;
	localparam int LAST_CNT    = `TXM_PAYLOAD_START + `TXM_PAYLOAD_LEN + 4;
	localparam int SLOT_W      = $clog2(`TXM_SEG_COUNT);

	typedef logic [SLOT_W-1:0] slot_t;

	logic       clk125MHz;
	logic       rst;
	pix_wr_t    pix_wr;
	logic       frame_start;
	txid_t      txid;
	seg_num_t   segment_num;
	byte_cnt_t  byte_counter;
	logic [7:0] data_byte;
	pix_addr_t  start_addr;

	rgb_t       shadow [`TXM_FRAME_PIXELS];             // what the frame buffer should hold
	logic [7:0] sent [`TXM_SEG_COUNT][`TXM_PAYLOAD_LEN]; // last first-send per slot
	pix_addr_t  start_rec [`TXM_SEG_COUNT];
	bit         rec_valid [`TXM_SEG_COUNT];
	pix_addr_t  model_ptr;   // running frame pointer model
	pix_addr_t  hold_start;  // start_addr between latches

	tx_memory_control i_tx_memory_control (
		.clk125MHz   (clk125MHz),
		.rst         (rst),
		.pix_wr      (pix_wr),
		.frame_start (frame_start),
		.txid        (txid),
		.segment_num (segment_num),
		.byte_counter(byte_counter),
		.data_byte   (data_byte),
		.start_addr  (start_addr)
	);

	initial begin
		clk125MHz = 1'b0;
		forever #HALF clk125MHz = ~clk125MHz;
	end

	// prefill pixel for one address
	function automatic rgb_t fill_pixel(input int a);
		rgb_t p;
		p.r = 8'(a * 4 + 1);
		p.g = 8'(255 - a);
		p.b = 8'((a * 7 + 3) ^ 'h5a);
		return p;
	endfunction

	// channel 0 red then green then blue
	function automatic logic [7:0] colour_of(input rgb_t p, input int ch);
		if (ch == 0)
			return p.r;
		else if (ch == 1)
			return p.g;
		return p.b;
	endfunction

	task automatic stop_with_failure();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// falling edge drive with strobes back to 0
	task automatic next_cycle(input int c);
		@(negedge clk125MHz);
		pix_wr.we    = 1'b0;
		frame_start  = 1'b0;
		byte_counter = byte_cnt_t'(c);
	endtask

	task automatic check_outputs(input int c, input logic [7:0] exp_byte,
		input pix_addr_t exp_start);
		#(HALF / 2); // middle of the low phase
		assert (data_byte === exp_byte) else begin
			$display("** Error: data_byte = %h, expected %h (byte_counter %h)",
				data_byte, exp_byte, c);
			stop_with_failure();
		end
		assert (start_addr === exp_start) else begin
			$display("** Error: start_addr = %h, expected %h (byte_counter %h)",
				start_addr, exp_start, c);
			stop_with_failure();
		end
	endtask

	task automatic idle_gap(input int k);
		repeat (k) begin
			next_cycle(0);
			check_outputs(0, 8'h00, hold_start);
		end
	endtask

	task automatic write_pixel(input pix_addr_t a, input rgb_t p);
		next_cycle(0);
		pix_wr.we    = 1'b1;
		pix_wr.addr  = a;
		pix_wr.pixel = p;
		shadow[a]    = p;
		check_outputs(0, 8'h00, hold_start);
	endtask

	task automatic pulse_frame_start();
		next_cycle(0);
		frame_start = 1'b1;
		model_ptr   = '0; // next first send starts at pixel 0
		check_outputs(0, 8'h00, hold_start);
	endtask

	task automatic run_packet(input txid_t tid, input seg_num_t seg, input pix_addr_t exp_start);
		logic [7:0] exp_bytes [`TXM_PAYLOAD_LEN];
		slot_t      slot;
		bit         first;
		pix_addr_t  model_start;
		logic [7:0] exp_b;
		pix_addr_t  exp_s;
		slot  = slot_t'(seg % `TXM_SEG_COUNT);
		first = (tid == txid_t'(`TXM_FIRST_TXID));
		model_start = model_ptr;
		if (!first && !rec_valid[slot]) begin
			$display("case file repeats segment %h before it was ever sent first", seg);
			stop_with_failure();
		end else if (!first) begin
			model_start = start_rec[slot];
		end
		if (model_start !== exp_start) begin
			$display("case file start pixel %h for segment %h disagrees with the model (%h)",
				exp_start, seg, model_start);
			stop_with_failure();
		end
		for (int n = 0; n < `TXM_PAYLOAD_LEN; n++) begin
			if (first)
				exp_bytes[pay_idx_t'(n)] = colour_of(
					shadow[pix_addr_t'((int'(model_ptr) + n / 3) % `TXM_FRAME_PIXELS)], n % 3);
			else
				exp_bytes[pay_idx_t'(n)] = sent[slot][pay_idx_t'(n)]; // replay
		end
		next_cycle(0);
		txid        = tid;  // held for the whole packet
		segment_num = seg;
		check_outputs(0, 8'h00, hold_start);
		for (int c = 1; c <= LAST_CNT; c++) begin
			next_cycle(c);
			if (c >= `TXM_PAYLOAD_START && c < `TXM_PAYLOAD_START + `TXM_PAYLOAD_LEN)
				exp_b = exp_bytes[pay_idx_t'(c - `TXM_PAYLOAD_START)];
			else
				exp_b = 8'h00;
			exp_s = (c > LATCH_CNT) ? exp_start : hold_start; // new value after latch
			check_outputs(c, exp_b, exp_s);
		end
		hold_start = exp_start;
		if (first) begin
			for (int n = 0; n < `TXM_PAYLOAD_LEN; n++)
				sent[slot][pay_idx_t'(n)] = exp_bytes[pay_idx_t'(n)];
			start_rec[slot] = exp_start;
			rec_valid[slot] = 1'b1;
			model_ptr = pix_addr_t'((int'(model_ptr) + `TXM_PAYLOAD_LEN / 3) % `TXM_FRAME_PIXELS);
		end
		idle_gap(2); // counter held at 0
	endtask

	initial begin
		int         fd;
		int         n;
		int         records;
		int         gap;
		bit         done;
		logic [7:0] kind;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_c;
		logic [8*200-1:0] rest; // rest of a comment line
		void'($urandom(57)); // seed for the idle gap draws
		rst          = 1'b1;
		pix_wr       = '0;
		frame_start  = 1'b0;
		txid         = '0;
		segment_num  = '0;
		byte_counter = '0;
		model_ptr    = '0;
		hold_start   = '0;
		for (int s = 0; s < `TXM_SEG_COUNT; s++)
			rec_valid[s] = 1'b0;
		repeat (2) @(negedge clk125MHz); // two rising edges in reset
		rst = 1'b0;
		check_outputs(0, 8'h00, '0);
		for (int a = 0; a < `TXM_FRAME_PIXELS; a++)
			write_pixel(pix_addr_t'(a), fill_pixel(a));

		fd = $fopen("testbench/tx_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/tx_cases.txt");
			stop_with_failure();
		end
		records = 0;
		done    = 1'b0;
		while (!done) begin
			n = $fscanf(fd, " %c", kind);
			if (n != 1) begin
				done = 1'b1; // end of file
			end else begin
				records++;
				if (records > MAX_RECORDS) begin
					$display("case file has more than %0d records", MAX_RECORDS);
					stop_with_failure();
				end
				case (kind)
					"#": void'($fgets(rest, fd)); // rest of the line
					"W": begin
						n = $fscanf(fd, "%h %h", f_a, f_b);
						if (n != 2) begin
							$display("malformed pixel write in case file, record %0d", records);
							stop_with_failure();
						end
						write_pixel(pix_addr_t'(f_a), rgb_t'(f_b[23:0]));
					end
					"F": pulse_frame_start();
					"P": begin
						n = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
						if (n != 3) begin
							$display("malformed packet line in case file, record %0d", records);
							stop_with_failure();
						end
						run_packet(txid_t'(f_a), seg_num_t'(f_b), pix_addr_t'(f_c));
						gap = int'($urandom % 4);
						idle_gap(gap);
					end
					default: begin
						$display("unknown record type '%c' in case file", kind);
						stop_with_failure();
					end
				endcase
			end
		end
		$fclose(fd);
		idle_gap(2);
		$display("Test OK");
		$finish;
	end

endmodule

//--- design/tx_memory_control.sv
// ----------------------------------------------------------
// tx payload memory control
// sequencer, frame buffer and retransmit store; registers the
// payload byte so it lines up with the byte counter
// ----------------------------------------------------------
`timescale 1ns/100ps

module tx_memory_control import txmem_pkg::*; (
	input  logic       clk125MHz,
	input  logic       rst,
	input  pix_wr_t    pix_wr,       // pixel writes, already in this clock
	input  logic       frame_start,
	input  txid_t      txid,
	input  seg_num_t   segment_num,
	input  byte_cnt_t  byte_counter,
	output logic [7:0] data_byte,    // payload byte, 0 outside payload
	output pix_addr_t  start_addr    // segment start pixel
);

	fetch_t     fetch;
	logic [7:0] pix_byte;
	logic [7:0] stored_byte;
	logic       valid_d, first_d;    // fetch flags at ram output

	payload_sequencer i_payload_sequencer (
		.clk125MHz   (clk125MHz),
		.rst         (rst),
		.txid        (txid),
		.segment_num (segment_num),
		.byte_counter(byte_counter),
		.frame_start (frame_start),
		.fetch       (fetch),
		.start_addr  (start_addr)
	);

	pixel_ram i_pixel_ram (
		.clk125MHz(clk125MHz),
		.pix_wr   (pix_wr),
		.fetch    (fetch),
		.pix_byte (pix_byte)
	);

	segment_store i_segment_store (
		.clk125MHz  (clk125MHz),
		.fetch      (fetch),
		.wr_byte    (data_byte),    // first transmission bytes go back in
		.stored_byte(stored_byte)
	);

	// stage 3, output register
	always_ff @(posedge clk125MHz) begin
		if (rst) begin
			valid_d   <= 1'b0;
			first_d   <= 1'b0;
			data_byte <= 8'h00;
		end else begin
			valid_d <= fetch.valid;
			first_d <= fetch.first;
			if (!valid_d)
				data_byte <= 8'h00;        // outside the window
			else if (first_d)
				data_byte <= pix_byte;     // fresh pixel data
			else
				data_byte <= stored_byte;  // replay
		end
	end

endmodule

//--- design/payload_sequencer.sv
// ----------------------------------------------------------
// payload sequencer
// picks first or repeat per packet, issues byte fetches three
// counts ahead of the payload, keeps the pixel pointer and
// the per-segment start pixel table
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "txmem_defines.svh"

module payload_sequencer import txmem_pkg::*; (
	input  logic      clk125MHz,
	input  logic      rst,
	input  txid_t     txid,         // held for the whole packet
	input  seg_num_t  segment_num,  // held for the whole packet
	input  byte_cnt_t byte_counter, // 0 between packets
	input  logic      frame_start,  // one-cycle pulse
	output fetch_t    fetch,
	output pix_addr_t start_addr
);

	localparam int SEG_W = $clog2(`TXM_SEG_COUNT);
	// fetch window, [WIN_LO, WIN_HI)
	localparam byte_cnt_t WIN_LO = byte_cnt_t'(`TXM_PAYLOAD_START - `TXM_FETCH_AHEAD);
	localparam byte_cnt_t WIN_HI = byte_cnt_t'(`TXM_PAYLOAD_START - `TXM_FETCH_AHEAD
		+ `TXM_PAYLOAD_LEN);
	// last payload byte on the wire
	localparam byte_cnt_t PAY_END = byte_cnt_t'(`TXM_PAYLOAD_START + `TXM_PAYLOAD_LEN - 1);
	localparam pix_addr_t PIX_STEP = pix_addr_t'(`TXM_PAYLOAD_LEN / 3); // pixels per packet

	seq_state_e state;
	pix_addr_t  ptr;                          // running frame pointer
	pix_addr_t  start_tab [`TXM_SEG_COUNT];   // start pixel per segment
	logic [SEG_W-1:0] seg_sel;
	byte_cnt_t  win_off;                      // counts past window start
	pay_idx_t   n;                            // payload byte index
	pix_addr_t  pix_off;                      // n / 3
	logic [1:0] chan;                         // n mod 3
	logic       in_window;
	logic       latch_now;                    // start pixel latch point

	assign seg_sel   = SEG_W'(segment_num % `TXM_SEG_COUNT);
	assign win_off   = byte_counter - WIN_LO;
	assign n         = pay_idx_t'(win_off);
	assign pix_off   = pix_addr_t'(n / 3);
	assign chan      = 2'(n % 3);
	assign in_window = (state != SEQ_IDLE) && (byte_counter >= WIN_LO)
		&& (byte_counter < WIN_HI);
	assign latch_now = (byte_counter == WIN_LO);

	// packet type chosen once per packet
	always_ff @(posedge clk125MHz) begin
		if (rst) begin
			state <= SEQ_IDLE;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (byte_counter == byte_cnt_t'(1))
						state <= (txid == txid_t'(`TXM_FIRST_TXID)) ? SEQ_FIRST : SEQ_REPEAT;
				end
				default: begin
					if (byte_counter == '0)
						state <= SEQ_IDLE; // packet done
				end
			endcase
		end
	end

	// frame pointer, moves once per first transmission
	always_ff @(posedge clk125MHz) begin
		if (rst)
			ptr <= '0;
		else if (frame_start)
			ptr <= '0; // new frame
		else if (state == SEQ_FIRST && byte_counter == PAY_END)
			ptr <= ptr + PIX_STEP; // wraps with the 6-bit address
	end

	// stage 1, registered fetch
	always_ff @(posedge clk125MHz) begin
		if (rst) begin
			fetch <= '0;
		end else begin
			fetch.valid <= in_window;
			fetch.first <= (state == SEQ_FIRST);
			fetch.addr  <= ptr + pix_off;
			fetch.chan  <= chan;
			fetch.seg   <= segment_num;
			fetch.idx   <= n;
		end
	end

	// start pixel table, filled on first transmissions
	always_ff @(posedge clk125MHz) begin
		if (state == SEQ_FIRST && latch_now)
			start_tab[seg_sel] <= ptr;
	end

	// start pixel for the header, held until next latch
	always_ff @(posedge clk125MHz) begin
		if (rst) begin
			start_addr <= '0;
		end else if (latch_now) begin
			if (state == SEQ_FIRST)
				start_addr <= ptr;
			else if (state == SEQ_REPEAT)
				start_addr <= start_tab[seg_sel]; // recorded on first send
		end
	end

endmodule

//--- design/segment_store.sv
// ----------------------------------------------------------
// retransmit store
// keeps one payload of bytes per segment; written from the
// output byte on first transmission, replayed on repeats
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "txmem_defines.svh"

module segment_store import txmem_pkg::*; (
	input  logic       clk125MHz,
	input  fetch_t     fetch,       // from sequencer
	input  logic [7:0] wr_byte,     // output byte fed back
	output logic [7:0] stored_byte
);

	localparam int DEPTH = `TXM_SEG_COUNT * `TXM_PAYLOAD_LEN;
	localparam int ST_W  = $clog2(DEPTH);
	localparam int SEG_W = $clog2(`TXM_SEG_COUNT);

	logic [7:0]      mem [DEPTH];
	logic [SEG_W-1:0] seg_sel;      // segment modulo store size
	logic [ST_W-1:0]  st_addr;      // flat address of current fetch
	logic [ST_W-1:0]  addr_d1, addr_d2;
	logic [1:0]       wr_d;         // valid && first, two stages

	assign seg_sel = SEG_W'(fetch.seg % `TXM_SEG_COUNT);
	assign st_addr = ST_W'(seg_sel * `TXM_PAYLOAD_LEN + fetch.idx);

	// delay line, lines up with data_byte at the top level
	always_ff @(posedge clk125MHz) begin
		wr_d    <= {wr_d[0], fetch.valid & fetch.first};
		addr_d1 <= st_addr;
		addr_d2 <= addr_d1;
	end

	always_ff @(posedge clk125MHz) begin
		if (wr_d[1])
			mem[addr_d2] <= wr_byte; // byte that just went out
		stored_byte <= mem[st_addr]; // repeat read, one cycle
	end

endmodule

//--- design/pixel_ram.sv
// ----------------------------------------------------------
// pixel frame buffer
// one pixel write port, registered read port on the fetch,
// colour byte picked with the delayed channel
// ----------------------------------------------------------
`timescale 1ns/100ps
`include "txmem_defines.svh"

module pixel_ram import txmem_pkg::*; (
	input  logic       clk125MHz,
	input  pix_wr_t    pix_wr,    // from pixel source
	input  fetch_t     fetch,     // from sequencer
	output logic [7:0] pix_byte
);

	rgb_t mem [`TXM_FRAME_PIXELS]; // frame buffer
	rgb_t pix_q;                   // registered read pixel
	logic [1:0] chan_q;            // channel aligned with pix_q

	// write port
	always_ff @(posedge clk125MHz) begin
		if (pix_wr.we)
			mem[pix_wr.addr] <= pix_wr.pixel;
	end

	// read every cycle and return old data on a same-address write
	always_ff @(posedge clk125MHz) begin
		pix_q  <= mem[fetch.addr];
		chan_q <= fetch.chan;
	end

	// byte select with r first on the wire
	always_comb begin
		case (chan_q)
			2'd0:    pix_byte = pix_q.r;
			2'd1:    pix_byte = pix_q.g;
			2'd2:    pix_byte = pix_q.b;
			default: pix_byte = 8'h00; // unused channel code
		endcase
	end

endmodule

//--- design/txmem_pkg.sv
// ----------------------------------------------------------
// tx payload memory types
// widths, pixel write and fetch structs, sequencer states
// ----------------------------------------------------------
package txmem_pkg;

	typedef logic [11:0] byte_cnt_t;  // upstream byte counter
	typedef logic [7:0]  txid_t;      // transmission id
	typedef logic [15:0] seg_num_t;   // segment number
	typedef logic [5:0]  pix_addr_t;  // frame buffer address
	typedef logic [3:0]  pay_idx_t;   // byte index in payload

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// pixel write port, 31 bits
	typedef struct packed {
		logic      we;
		pix_addr_t addr;
		rgb_t      pixel;
	} pix_wr_t;

	// one payload byte request, 30 bits
	typedef struct packed {
		logic       valid;
		logic       first; // first transmission, read frame buffer
		pix_addr_t  addr;  // pixel address
		logic [1:0] chan;  // 0 r, 1 g, 2 b
		seg_num_t   seg;
		pay_idx_t   idx;   // byte index, store address
	} fetch_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FIRST,
		SEQ_REPEAT
	} seq_state_e;

endpackage

//--- design/txmem_defines.svh
// ----------------------------------------------------------
// tx payload memory constants
// segment count, payload geometry, fetch depth and frame size
// ----------------------------------------------------------
`ifndef TXM_DEFINES_SVH
`define TXM_DEFINES_SVH

// segments per frame, sets retransmit store depth
`define TXM_SEG_COUNT      4
// payload bytes per packet, multiple of 3 (r, g, b)
`define TXM_PAYLOAD_LEN    12
`define TXM_PAYLOAD_START  16  // byte counter of first payload byte
`define TXM_FETCH_AHEAD    3   // fetch, ram read, output reg
// frame buffer depth in pixels
`define TXM_FRAME_PIXELS   64
`define TXM_FIRST_TXID     1   // txid of first transmission

`endif
